//--- all.f
rtl/led_pkg.sv
rtl/scan_if.sv
rtl/host_port.sv
rtl/panel_bank.sv
rtl/scan_sequencer.sv
rtl/hub75_driver.sv
rtl/led_matrix.sv
bench/tb_clock.sv
bench/led_matrix_assert.sv
bench/led_matrix_tb.sv

//--- bench/led_matrix_tb.sv
`timescale 1ns/1ps
`default_nettype none

module led_matrix_tb;

  localparam int BLANK        = 4;
  localparam int PASS_CYCLES  = 3 * led_pkg::NUM_COLS + 2 * BLANK + 3;
  localparam int CHECK_PASSES = 64;  // eight PWM levels over every row.

  logic                csi_clk;
  logic                rsi_reset_n;
  led_pkg::host_word_t data_in;
  led_pkg::host_addr_t address;
  logic                write;
  led_pkg::host_word_t data_out;
  logic                rgb_a;
  logic                rgb_b;
  logic                rgb_c;
  led_pkg::lane_t      rgb0;
  led_pkg::lane_t      rgb1;
  logic                rgb_clk;
  logic                rgb_stb;
  logic                oe_n;

  logic [15:0]         model [1024];  // host view of both banks.
  logic [31:0]         seed = 32'h577f_c60b;
  int                  latch_count;   // row passes shown so far, which is the scan phase.
  int                  clk_count;
  int                  pwm_count;
  logic                addr_due;
  logic                check_pwm = 1'b0;
  led_pkg::host_addr_t written [$];

  tb_clock u_clk (.csi_clk(csi_clk), .rsi_reset_n(rsi_reset_n));

  led_matrix #(.BLANK_CYCLES(BLANK)) uut (
    .csi_clk (csi_clk), .rsi_reset_n (rsi_reset_n),
    .data_in (data_in), .address (address), .write (write), .data_out (data_out),
    .rgb_a (rgb_a), .rgb_b (rgb_b), .rgb_c (rgb_c), .rgb0 (rgb0), .rgb1 (rgb1),
    .rgb_clk (rgb_clk), .rgb_stb (rgb_stb), .oe_n (oe_n)
  );

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // a channel is lit while the level is below its value.
  function automatic led_pkg::lane_t expected_lane(input logic half, input led_pkg::row_t row,
                                                   input led_pkg::col_t col,
                                                   input led_pkg::level_t level);
    logic [15:0] rg;
    logic [15:0] bx;
    rg = model[{half, row, col, 1'b0}];
    bx = model[{half, row, col, 1'b1}];
    return {level < rg[15:8], level < rg[7:0], level < bx[15:8]};
  endfunction

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic fail_mismatch(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
    abort_run();
  endtask

  task automatic fail_reason(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  task automatic write_word(input led_pkg::host_addr_t a, input led_pkg::host_word_t d);
    @(negedge csi_clk);
    address  = a;
    data_in  = d;
    write    = 1'b1;
    model[a] = d;
  endtask

  task automatic read_check(input led_pkg::host_addr_t a);
    @(negedge csi_clk);
    address = a;
    write   = 1'b0;
    @(negedge csi_clk);
    assert (data_out === model[a])
      else fail_mismatch($sformatf("host readback at %h", a), model[a], data_out);
  endtask

  task automatic release_bus();
    @(negedge csi_clk);
    write = 1'b0;
  endtask

  task automatic wait_latches(input int target, input int max_cycles);
    int n;
    n = 0;
    while (latch_count < target) begin
      if (n == max_cycles) fail_reason("timed out waiting for a latch pulse on the panel");
      @(posedge csi_clk);
      n++;
    end
  endtask

  // ------------------------------------------------------------------
  // pin monitor
  // ------------------------------------------------------------------
  always @(negedge csi_clk) begin : monitor
    led_pkg::lane_t exp0;
    led_pkg::lane_t exp1;
    if (!rsi_reset_n) begin
      latch_count <= 0;
      clk_count   <= 0;
      pwm_count   <= 0;
      addr_due    <= 1'b0;
    end else begin
      if (uut.u_pin_assert.violations != 0) fail_reason("a panel pin protocol rule was broken");
      if (rgb_clk) begin
        if (check_pwm) begin
          exp0 = expected_lane(1'b0, led_pkg::row_t'(latch_count), led_pkg::col_t'(clk_count),
                               led_pkg::level_t'(latch_count / 8));
          exp1 = expected_lane(1'b1, led_pkg::row_t'(latch_count), led_pkg::col_t'(clk_count),
                               led_pkg::level_t'(latch_count / 8));
          assert (rgb0 === exp0) else fail_mismatch($sformatf("rgb0 phase %0d col %0d",
                                                     latch_count, clk_count), exp0, rgb0);
          assert (rgb1 === exp1) else fail_mismatch($sformatf("rgb1 phase %0d col %0d",
                                                     latch_count, clk_count), exp1, rgb1);
          pwm_count <= pwm_count + 1;
        end
        clk_count <= clk_count + 1;
      end
      if (rgb_stb) begin
        assert (clk_count == led_pkg::NUM_COLS)
          else fail_mismatch("shift count", led_pkg::NUM_COLS, clk_count);
        assert (oe_n) else fail_reason("oe_n is low during the latch pulse");
        latch_count <= latch_count + 1;
        clk_count   <= 0;
        addr_due    <= 1'b1;
      end else if (addr_due) begin
        assert ({rgb_c, rgb_b, rgb_a} === led_pkg::row_t'(latch_count - 1))
          else fail_mismatch("row address", led_pkg::row_t'(latch_count - 1),
                             {rgb_c, rgb_b, rgb_a});
        assert (oe_n) else fail_reason("oe_n is low right after the latch pulse");
        addr_due <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------
  initial begin : main
    int n;
    int start;
    led_pkg::host_addr_t a;
    logic [7:0] ch [3];
    data_in = '0;
    address = '0;
    write   = 1'b0;

    n = 0;
    @(negedge csi_clk);
    while (!rsi_reset_n) begin
      assert (!rgb_clk && !rgb_stb && oe_n) else fail_reason("panel pins are not idle in reset");
      if (n == 20) fail_reason("reset was never released");
      @(negedge csi_clk);
      n++;
    end

    // each word also goes to the same address in the other half.
    for (int i = 0; i < 64; i++) begin
      seed = lcg_next(seed);
      a = seed[25:16];
      write_word(a, seed[15:0]);
      seed = lcg_next(seed);
      write_word(a ^ 10'h200, seed[31:16]);
      written.push_back(a);
      written.push_back(a ^ 10'h200);
    end
    release_bus();
    foreach (written[i]) read_check(written[i]);

    wait_latches(latch_count + 2, 3 * PASS_CYCLES);

    // the full frame has dark and full columns and some low channel values.
    for (int h = 0; h < led_pkg::NUM_HALVES; h++) begin
      for (int r = 0; r < led_pkg::NUM_ROWS; r++) begin
        for (int c = 0; c < led_pkg::NUM_COLS; c++) begin
          for (int k = 0; k < 3; k++) begin
            seed = lcg_next(seed);
            ch[k] = (seed[27:26] == 2'b00) ? {5'd0, seed[10:8]} : seed[23:16];
            if (c == 0) ch[k] = 8'h00;
            if (c == led_pkg::NUM_COLS - 1) ch[k] = 8'hff;
          end
          a = {h[0], r[2:0], c[4:0], 1'b0};
          write_word(a, {ch[0], ch[1]});
          write_word(a | 10'h001, {ch[2], seed[7:0]});
        end
      end
    end
    release_bus();

    wait_latches(latch_count + 1, 2 * PASS_CYCLES);
    check_pwm = 1'b1;
    start = latch_count;
    wait_latches(start + CHECK_PASSES, (CHECK_PASSES + 2) * PASS_CYCLES);
    check_pwm = 1'b0;
    assert (pwm_count == CHECK_PASSES * led_pkg::NUM_COLS)
      else fail_mismatch("checked pulses", CHECK_PASSES * led_pkg::NUM_COLS, pwm_count);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/led_matrix_assert.sv
`timescale 1ns/1ps
`default_nettype none

module led_matrix_assert (
  input wire csi_clk,
  input wire rsi_reset_n,
  input wire rgb_clk,
  input wire rgb_stb,
  input wire oe_n
);

  int violations = 0;

  // ------------------------------------------------------------------
  // panel pin protocol
  // ------------------------------------------------------------------
  clk_stb_apart: assert property (
    @(posedge csi_clk) disable iff (!rsi_reset_n) !(rgb_clk && rgb_stb)
  ) else begin
    $error("rgb_clk and rgb_stb are high in the same cycle");
    violations++;
  end

  // the panel must be dark while a new row is latched.
  stb_while_dark: assert property (
    @(posedge csi_clk) disable iff (!rsi_reset_n) rgb_stb |-> oe_n
  ) else begin
    $error("rgb_stb is high while oe_n is low");
    violations++;
  end

  clk_single_pulse: assert property (
    @(posedge csi_clk) disable iff (!rsi_reset_n) rgb_clk |=> !rgb_clk
  ) else begin
    $error("rgb_clk stays high for two cycles");
    violations++;
  end

endmodule

bind led_matrix led_matrix_assert u_pin_assert (
  .csi_clk     (csi_clk),
  .rsi_reset_n (rsi_reset_n),
  .rgb_clk     (rgb_clk),
  .rgb_stb     (rgb_stb),
  .oe_n        (oe_n)
);

`default_nettype wire

//--- bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic csi_clk,
  output logic rsi_reset_n
);

  initial begin
    csi_clk = 1'b0;
    forever #50 csi_clk = ~csi_clk;  // 100 ns period.
  end

  // reset spans four rising edges and lifts on a falling edge.
  initial begin
    rsi_reset_n = 1'b0;
    repeat (4) @(posedge csi_clk);
    @(negedge csi_clk);
    rsi_reset_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- rtl/led_matrix.sv
`timescale 1ns/1ps
`default_nettype none

module led_matrix #(
  parameter int BLANK_CYCLES = 32
) (
  input  wire                 csi_clk,
  input  wire                 rsi_reset_n,

  input  led_pkg::host_word_t data_in,
  input  led_pkg::host_addr_t address,
  input  wire                 write,
  output led_pkg::host_word_t data_out,

  output logic                rgb_a,
  output logic                rgb_b,
  output logic                rgb_c,
  output led_pkg::lane_t      rgb0,
  output led_pkg::lane_t      rgb1,
  output logic                rgb_clk,
  output logic                rgb_stb,
  output logic                oe_n
);

  led_pkg::pixel_addr_t            bank_addr;
  logic                            bank_half;
  led_pkg::host_word_t             bank_wdata;
  logic [led_pkg::NUM_HALVES-1:0]  bank_write;
  led_pkg::host_word_t             bank_rdata [led_pkg::NUM_HALVES];

  led_pkg::lane_t                  lanes [led_pkg::NUM_HALVES];
  logic [led_pkg::NUM_HALVES-1:0]  lane_valid;

  logic                            shift;
  logic                            latch;
  logic                            blank;
  led_pkg::row_t                   shown_row;

  scan_if scan_bus ();

  host_port u_host (
    .csi_clk     (csi_clk),
    .rsi_reset_n (rsi_reset_n),
    .address     (address),
    .data_in     (data_in),
    .write       (write),
    .bank_addr   (bank_addr),
    .bank_half   (bank_half),
    .bank_wdata  (bank_wdata),
    .bank_write  (bank_write),
    .bank_rdata  (bank_rdata),
    .data_out    (data_out)
  );

  scan_sequencer #(
    .BLANK_CYCLES (BLANK_CYCLES)
  ) u_seq (
    .csi_clk     (csi_clk),
    .rsi_reset_n (rsi_reset_n),
    .scan        (scan_bus.seq),
    .shift       (shift),
    .latch       (latch),
    .blank       (blank),
    .shown_row   (shown_row)
  );

  // both halves scan in lockstep from the same position.
  for (genvar i = 0; i < led_pkg::NUM_HALVES; i++) begin : g_bank
    panel_bank u_bank (
      .csi_clk     (csi_clk),
      .rsi_reset_n (rsi_reset_n),
      .scan        (scan_bus.bank),
      .host_addr   (bank_addr),
      .host_half   (bank_half),
      .host_wdata  (bank_wdata),
      .host_write  (bank_write[i]),
      .host_rdata  (bank_rdata[i]),
      .lane        (lanes[i]),
      .lane_valid  (lane_valid[i])
    );
  end

  hub75_driver u_drv (
    .csi_clk     (csi_clk),
    .rsi_reset_n (rsi_reset_n),
    .lanes       (lanes),
    .lane_valid  (lane_valid),
    .shift       (shift),
    .latch       (latch),
    .blank       (blank),
    .shown_row   (shown_row),
    .rgb0        (rgb0),
    .rgb1        (rgb1),
    .rgb_a       (rgb_a),
    .rgb_b       (rgb_b),
    .rgb_c       (rgb_c),
    .rgb_clk     (rgb_clk),
    .rgb_stb     (rgb_stb),
    .oe_n        (oe_n)
  );

endmodule

`default_nettype wire

//--- rtl/hub75_driver.sv
`timescale 1ns/1ps
`default_nettype none

module hub75_driver (
  input  wire                            csi_clk,
  input  wire                            rsi_reset_n,

  input  led_pkg::lane_t                 lanes [led_pkg::NUM_HALVES],
  input  wire [led_pkg::NUM_HALVES-1:0]  lane_valid,

  input  wire                            shift,
  input  wire                            latch,
  input  wire                            blank,
  input  led_pkg::row_t                  shown_row,

  output led_pkg::lane_t                 rgb0,
  output led_pkg::lane_t                 rgb1,
  output logic                           rgb_a,
  output logic                           rgb_b,
  output logic                           rgb_c,
  output logic                           rgb_clk,
  output logic                           rgb_stb,
  output logic                           oe_n
);

  // ------------------------------------------------------------------
  // pin registers
  // ------------------------------------------------------------------
  // Lane data reaches the pins in the same cycle as the shift strobe
  // and is held until the next column arrives, so it is stable for
  // the whole rgb_clk pulse.
  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      rgb0    <= '0;
      rgb1    <= '0;
      rgb_a   <= 1'b0;
      rgb_b   <= 1'b0;
      rgb_c   <= 1'b0;
      rgb_clk <= 1'b0;
      rgb_stb <= 1'b0;
      oe_n    <= 1'b1;  // panel dark while in reset.
    end else begin
      if (lane_valid[0]) begin
        rgb0 <= lanes[0];  // upper half-panel.
      end
      if (lane_valid[1]) begin
        rgb1 <= lanes[1];
      end
      rgb_clk <= shift;
      rgb_stb <= latch;
      oe_n    <= blank;
      // row address moves while oe_n is still high.
      rgb_a <= shown_row[0];
      rgb_b <= shown_row[1];
      rgb_c <= shown_row[2];
    end
  end

endmodule

`default_nettype wire

//--- rtl/scan_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module scan_sequencer #(
  parameter int BLANK_CYCLES = 32
) (
  input  wire            csi_clk,
  input  wire            rsi_reset_n,

  scan_if.seq            scan,

  output logic           shift,
  output logic           latch,
  output logic           blank,
  output led_pkg::row_t  shown_row
);

  // wide enough to hold BLANK_CYCLES, and at least one bit.
  localparam int CNT_W = $clog2(BLANK_CYCLES + 2);
  localparam logic [CNT_W-1:0] BLANK_LOAD = CNT_W'(BLANK_CYCLES);
  localparam led_pkg::col_t LAST_COL = led_pkg::col_t'(led_pkg::NUM_COLS - 1);

  localparam int PHASE_W = $bits(led_pkg::row_t) + $bits(led_pkg::level_t);

  led_pkg::scan_state_t state;
  led_pkg::col_t        col;
  logic [PHASE_W-1:0]   phase;      // holds {level, row} and steps once per row pass.
  logic [CNT_W-1:0]     blank_cnt;

  // ------------------------------------------------------------------
  // state machine
  // ------------------------------------------------------------------
  // Each column is FETCH, IDLE, SHIFT. After the last column the
  // outputs are blanked around the latch pulse.
  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      state     <= led_pkg::FETCH;
      col       <= '0;
      phase     <= '0;
      blank_cnt <= '0;
      shown_row <= '0;
    end else begin
      case (state)
        led_pkg::FETCH: begin
          state <= led_pkg::IDLE;
        end

        led_pkg::IDLE: begin
          state <= led_pkg::SHIFT;  // banks compare during this cycle.
        end

        led_pkg::SHIFT: begin
          col <= col + 1'b1;
          if (col == LAST_COL) begin
            state     <= led_pkg::BLANK_PRE;
            blank_cnt <= BLANK_LOAD;
          end else begin
            state <= led_pkg::FETCH;
          end
        end

        led_pkg::BLANK_PRE: begin
          if (blank_cnt == '0) begin
            state <= led_pkg::LATCH;
          end else begin
            blank_cnt <= blank_cnt - 1'b1;
          end
        end

        led_pkg::LATCH: begin
          shown_row <= phase[2:0];  // this row goes on display now.
          phase     <= phase + 1'b1;
          blank_cnt <= BLANK_LOAD;
          state     <= led_pkg::BLANK_POST;
        end

        led_pkg::BLANK_POST: begin
          if (blank_cnt == '0) begin
            state <= led_pkg::FETCH;
          end else begin
            blank_cnt <= blank_cnt - 1'b1;
          end
        end

        default: begin
          state <= led_pkg::FETCH;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------------
  assign scan.row   = phase[2:0];
  assign scan.level = phase[PHASE_W-1:3];
  assign scan.col   = col;
  assign scan.fetch = (state == led_pkg::FETCH);

  assign shift = (state == led_pkg::SHIFT);
  assign latch = (state == led_pkg::LATCH);
  assign blank = (state == led_pkg::BLANK_PRE) || (state == led_pkg::LATCH) ||
                 (state == led_pkg::BLANK_POST);

endmodule

`default_nettype wire

//--- rtl/panel_bank.sv
`timescale 1ns/1ps
`default_nettype none

module panel_bank (
  input  wire                   csi_clk,
  input  wire                   rsi_reset_n,

  scan_if.bank                  scan,

  input  led_pkg::pixel_addr_t  host_addr,
  input  wire                   host_half,
  input  led_pkg::host_word_t   host_wdata,
  input  wire                   host_write,
  output led_pkg::host_word_t   host_rdata,

  output led_pkg::lane_t        lane,
  output logic                  lane_valid
);

  localparam int DEPTH = led_pkg::NUM_ROWS * led_pkg::NUM_COLS;

  led_pkg::pixel_t      mem [DEPTH];
  led_pkg::pixel_t      pix_q;     // pixel fetched for the current column.
  led_pkg::pixel_addr_t scan_addr;
  logic                 fetch_q;
  led_pkg::level_t      red;
  led_pkg::level_t      green;
  led_pkg::level_t      blue;

  assign scan_addr = {scan.row, scan.col};

  // ------------------------------------------------------------------
  // pixel memory, host half-word port and scan read port
  // ------------------------------------------------------------------
  always_ff @(posedge csi_clk) begin
    if (host_write) begin
      if (host_half) begin
        mem[host_addr][31:16] <= host_wdata;
      end else begin
        mem[host_addr][15:0] <= host_wdata;
      end
    end
    // a write to the same word returns the old contents here.
    host_rdata <= host_half ? mem[host_addr][31:16] : mem[host_addr][15:0];
    if (scan.fetch) begin
      pix_q <= mem[scan_addr];
    end
  end

  // ------------------------------------------------------------------
  // PWM compare
  // ------------------------------------------------------------------
  assign blue  = pix_q[31:24];
  assign red   = pix_q[15:8];
  assign green = pix_q[7:0];

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      fetch_q    <= 1'b0;
      lane       <= '0;
      lane_valid <= 1'b0;
    end else begin
      fetch_q    <= scan.fetch;
      lane_valid <= fetch_q;
      if (fetch_q) begin
        // the level only moves at latch, so it still matches the fetch.
        lane <= {scan.level < red, scan.level < green, scan.level < blue};
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/host_port.sv
`timescale 1ns/1ps
`default_nettype none

module host_port (
  input  wire                 csi_clk,
  input  wire                 rsi_reset_n,

  input  led_pkg::host_addr_t address,
  input  led_pkg::host_word_t data_in,
  input  wire                 write,

  output led_pkg::pixel_addr_t              bank_addr,
  output logic                              bank_half,
  output led_pkg::host_word_t               bank_wdata,
  output logic [led_pkg::NUM_HALVES-1:0]    bank_write,
  input  led_pkg::host_word_t               bank_rdata [led_pkg::NUM_HALVES],

  output led_pkg::host_word_t data_out
);

  logic half_sel;
  logic half_q;

  // ------------------------------------------------------------------
  // address decode
  // ------------------------------------------------------------------
  assign half_sel   = address[9];
  assign bank_addr  = address[8:1];  // {row, col}.
  assign bank_half  = address[0];    // 1 selects blue and the spare byte.
  assign bank_wdata = data_in;

  // only the addressed half-panel sees the strobe.
  for (genvar h = 0; h < led_pkg::NUM_HALVES; h++) begin : g_wr
    assign bank_write[h] = write && (half_sel == 1'(h));
  end

  // ------------------------------------------------------------------
  // readback
  // ------------------------------------------------------------------
  // The banks register their read word, so the select has to be
  // held for one cycle to pick the right one.
  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      half_q <= 1'b0;
    end else begin
      half_q <= half_sel;
    end
  end

  assign data_out = bank_rdata[half_q];  // valid one cycle after address.

endmodule

`default_nettype wire

//--- rtl/scan_if.sv
`timescale 1ns/1ps
`default_nettype none

// scan position shared by the sequencer and every bank.
interface scan_if;

  led_pkg::row_t   row;
  led_pkg::col_t   col;
  led_pkg::level_t level;
  logic            fetch;  // one-cycle strobe on which the banks read the pixel at row/col.

  modport seq (
    output row,
    output col,
    output level,
    output fetch
  );

  modport bank (
    input row,
    input col,
    input level,
    input fetch
  );

endinterface

`default_nettype wire

//--- rtl/led_pkg.sv
`default_nettype none

package led_pkg;

  // ------------------------------------------------------------------
  // panel geometry
  // ------------------------------------------------------------------
  localparam int NUM_HALVES = 2;  // half-panels, scanned together.
  localparam int NUM_ROWS   = 8;  // rows in each half.
  localparam int NUM_COLS   = 32;

  // ------------------------------------------------------------------
  // vector types
  // ------------------------------------------------------------------
  typedef logic [$clog2(NUM_ROWS)-1:0] row_t;
  typedef logic [$clog2(NUM_COLS)-1:0] col_t;
  typedef logic [7:0]                  level_t;

  // pixel index within one bank with the row in the upper bits.
  typedef logic [$bits(row_t)+$bits(col_t)-1:0] pixel_addr_t;

  // host address is {half, row, col, half-word}.
  typedef logic [9:0]  host_addr_t;
  typedef logic [15:0] host_word_t;

  // blue 31:24, spare 23:16, red 15:8, green 7:0.
  typedef logic [31:0] pixel_t;

  typedef logic [2:0] lane_t;  // {red, green, blue}.

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    SHIFT,
    BLANK_PRE,
    LATCH,
    BLANK_POST
  } scan_state_t;

endpackage

`default_nettype wire
